//--- Makefile
# Verilator build and run of the vga overlay testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_vga_overlay
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
rtl/vga_overlay_pkg.sv
rtl/vga_scan_timer.sv
rtl/layer_reg_bank.sv
rtl/layer_rect_render.sv
rtl/pixel_combiner.sv
rtl/vga_overlay_top.sv
test/vga_overlay_properties.sv
test/tb_vga_overlay.sv

//--- rtl/layer_rect_render.sv
// ######################################
// layer rectangle renderer.
// colour inside the rectangle, black
// everywhere else.
// ######################################

`timescale 1ns/1ps
`default_nettype none

module layer_rect_render
	import vga_overlay_pkg::*;
(
	input  coord_t scan_x,
	input  coord_t scan_y,
	input  coord_t x_start,
	input  coord_t x_end,
	input  coord_t y_start,
	input  coord_t y_end,
	input  pixel_t color,
	input  logic   enable,
	output pixel_t pixel
);

	logic x_hit;
	logic y_hit;

	// start inclusive, end exclusive; an empty span never hits.
	assign x_hit = (scan_x >= x_start) && (scan_x < x_end);
	assign y_hit = (scan_y >= y_start) && (scan_y < y_end);

	assign pixel = (enable && x_hit && y_hit) ? color : '0;

endmodule

`default_nettype wire

//--- rtl/layer_reg_bank.sv
// ######################################
// layer register bank.
// wishbone classic slave holding the
// rectangle, colour and enable of
// every layer.
// ######################################

`timescale 1ns/1ps
`default_nettype none

module layer_reg_bank
	import vga_overlay_pkg::*;
#(
	parameter int NUM_LAYERS = 4
)
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  wb_addr_t                   wb_adr,
	input  wb_data_t                   wb_dat_w,
	output wb_data_t                   wb_dat_r,
	output logic                       wb_ack,
	output coord_t   [NUM_LAYERS-1:0]  x_start,
	output coord_t   [NUM_LAYERS-1:0]  x_end,
	output coord_t   [NUM_LAYERS-1:0]  y_start,
	output coord_t   [NUM_LAYERS-1:0]  y_end,
	output pixel_t   [NUM_LAYERS-1:0]  color,
	output logic     [NUM_LAYERS-1:0]  enable
);

	typedef enum logic {IDLE, ACK} wb_state_t;

	wb_state_t state;
	logic [4:0] layer_sel;
	logic [2:0] reg_sel;
	logic       req;
	wb_data_t   rd_data;

	assign layer_sel = wb_adr[7:3];
	assign reg_sel   = wb_adr[2:0];
	assign req       = (state == IDLE) && wb_cyc && wb_stb;
	assign wb_ack    = (state == ACK); // high for a single cycle.

	// read mux returns zero for unknown layers and registers.
	always_comb
	begin
		rd_data = '0;
		for (int i = 0; i < NUM_LAYERS; i++)
		begin
			if (int'(layer_sel) == i)
			begin
				case (reg_sel)
					REG_X_START: rd_data = wb_data_t'(x_start[i]);
					REG_X_END:   rd_data = wb_data_t'(x_end[i]);
					REG_Y_START: rd_data = wb_data_t'(y_start[i]);
					REG_Y_END:   rd_data = wb_data_t'(y_end[i]);
					REG_COLOR:
					begin
						rd_data               = wb_data_t'(color[i]);
						rd_data[COLOR_EN_BIT] = enable[i];
					end
					default:     rd_data = '0;
				endcase
			end
		end
	end

	// handshake fsm and the enable bits.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= IDLE;
			enable <= '0;
		end
		else
		begin
			case (state)
				IDLE: if (req) state <= ACK;
				ACK:  state <= IDLE; // master drops stb on seeing ack.
			endcase
			for (int i = 0; i < NUM_LAYERS; i++)
				if (req && wb_we && int'(layer_sel) == i && reg_sel == REG_COLOR)
					enable[i] <= wb_dat_w[COLOR_EN_BIT];
		end
	end

	// rectangle and colour storage, plus the read data latch.
	always_ff @(posedge clk)
	begin
		if (req)
			wb_dat_r <= rd_data;
		for (int i = 0; i < NUM_LAYERS; i++)
		begin
			if (req && wb_we && int'(layer_sel) == i)
			begin
				case (reg_sel)
					REG_X_START: x_start[i] <= wb_dat_w[$bits(coord_t)-1:0];
					REG_X_END:   x_end[i]   <= wb_dat_w[$bits(coord_t)-1:0];
					REG_Y_START: y_start[i] <= wb_dat_w[$bits(coord_t)-1:0];
					REG_Y_END:   y_end[i]   <= wb_dat_w[$bits(coord_t)-1:0];
					REG_COLOR:   color[i]   <= wb_dat_w[$bits(pixel_t)-1:0];
					default:     ; // unused index.
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/pixel_combiner.sv
// ######################################
// pixel combiner.
// registered or of all layer pixels,
// syncs delayed to stay aligned.
// ######################################

`timescale 1ns/1ps
`default_nettype none

module pixel_combiner
	import vga_overlay_pkg::*;
#(
	parameter int NUM_LAYERS = 4
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  pixel_t [NUM_LAYERS-1:0]  layer_pixels,
	input  logic                     scan_active,
	input  logic                     scan_hsync,
	input  logic                     scan_vsync,
	output pixel_t                   vga_rgb,
	output logic                     vga_hsync,
	output logic                     vga_vsync
);

	pixel_t mix;

	// overlapping layers mix their colour bits.
	always_comb
	begin
		mix = '0;
		for (int i = 0; i < NUM_LAYERS; i++)
			mix = mix | layer_pixels[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vga_rgb   <= '0;
			vga_hsync <= 1'b1; // syncs idle high.
			vga_vsync <= 1'b1;
		end
		else
		begin
			vga_rgb   <= scan_active ? mix : '0; // black in blanking.
			vga_hsync <= scan_hsync;
			vga_vsync <= scan_vsync;
		end
	end

endmodule

`default_nettype wire

//--- rtl/vga_overlay_pkg.sv
// ######################################
// vga overlay shared types.
// pixel, coordinate and bus word types,
// plus the layer register map.
// ######################################

`default_nettype none

package vga_overlay_pkg;

	typedef logic [11:0] pixel_t;   // 4 bits each of r, g, b.
	typedef logic [10:0] coord_t;   // screen x or y.

	typedef logic [7:0]  wb_addr_t; // word address with the layer in [7:3] and the register in [2:0].
	typedef logic [15:0] wb_data_t;

	// register index within one layer.
	localparam logic [2:0] REG_X_START = 3'd0;
	localparam logic [2:0] REG_X_END   = 3'd1; // exclusive.
	localparam logic [2:0] REG_Y_START = 3'd2;
	localparam logic [2:0] REG_Y_END   = 3'd3; // exclusive.
	localparam logic [2:0] REG_COLOR   = 3'd4;

	// enable sits just above the colour bits.
	localparam int COLOR_EN_BIT = 12;

endpackage

`default_nettype wire

//--- rtl/vga_overlay_top.sv
// ######################################
// vga overlay top level.
// scan timer, register bank, one renderer
// per layer and the pixel combiner.
// ######################################

`timescale 1ns/1ps
`default_nettype none

module vga_overlay_top
	import vga_overlay_pkg::*;
#(
	parameter int NUM_LAYERS = 4,
	parameter int H_ACTIVE   = 640,
	parameter int H_FRONT    = 16,
	parameter int H_SYNC     = 96,
	parameter int H_BACK     = 48,
	parameter int V_ACTIVE   = 480,
	parameter int V_FRONT    = 10,
	parameter int V_SYNC     = 2,
	parameter int V_BACK     = 33
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_w,
	output wb_data_t wb_dat_r,
	output logic     wb_ack,
	output pixel_t   vga_rgb,
	output logic     vga_hsync,
	output logic     vga_vsync
);

	coord_t scan_x;
	coord_t scan_y;
	logic   scan_active;
	logic   scan_hsync;
	logic   scan_vsync;

	coord_t [NUM_LAYERS-1:0] x_start;
	coord_t [NUM_LAYERS-1:0] x_end;
	coord_t [NUM_LAYERS-1:0] y_start;
	coord_t [NUM_LAYERS-1:0] y_end;
	pixel_t [NUM_LAYERS-1:0] color;
	logic   [NUM_LAYERS-1:0] enable;
	pixel_t [NUM_LAYERS-1:0] layer_pixels;

	vga_scan_timer #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) vga_scan_timer_i (
		.clk         (clk),
		.reset       (reset),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.scan_active (scan_active),
		.scan_hsync  (scan_hsync),
		.scan_vsync  (scan_vsync)
	);

	layer_reg_bank #(
		.NUM_LAYERS (NUM_LAYERS)
	) layer_reg_bank_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.x_start  (x_start),
		.x_end    (x_end),
		.y_start  (y_start),
		.y_end    (y_end),
		.color    (color),
		.enable   (enable)
	);

	// one combinational renderer per layer.
	for (genvar i = 0; i < NUM_LAYERS; i++)
	begin : g_layer
		layer_rect_render layer_rect_render_i (
			.scan_x  (scan_x),
			.scan_y  (scan_y),
			.x_start (x_start[i]),
			.x_end   (x_end[i]),
			.y_start (y_start[i]),
			.y_end   (y_end[i]),
			.color   (color[i]),
			.enable  (enable[i]),
			.pixel   (layer_pixels[i])
		);
	end

	pixel_combiner #(
		.NUM_LAYERS (NUM_LAYERS)
	) pixel_combiner_i (
		.clk          (clk),
		.reset        (reset),
		.layer_pixels (layer_pixels),
		.scan_active  (scan_active),
		.scan_hsync   (scan_hsync),
		.scan_vsync   (scan_vsync),
		.vga_rgb      (vga_rgb),
		.vga_hsync    (vga_hsync),
		.vga_vsync    (vga_vsync)
	);

endmodule

`default_nettype wire

//--- rtl/vga_scan_timer.sv
// ######################################
// vga scan timer.
// free running h/v counters with the
// active flag and low active syncs.
// ######################################

`timescale 1ns/1ps
`default_nettype none

module vga_scan_timer
	import vga_overlay_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
)
(
	input  logic   clk,
	input  logic   reset,
	output coord_t scan_x,
	output coord_t scan_y,
	output logic   scan_active,
	output logic   scan_hsync,
	output logic   scan_vsync
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);
	localparam coord_t H_VIS    = coord_t'(H_ACTIVE);
	localparam coord_t V_VIS    = coord_t'(V_ACTIVE);
	localparam coord_t HS_BEGIN = coord_t'(H_ACTIVE + H_FRONT);
	localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam coord_t VS_BEGIN = coord_t'(V_ACTIVE + V_FRONT);
	localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

	coord_t x_next;
	coord_t y_next;

	// next scan position.
	always_comb
	begin
		x_next = (scan_x == H_LAST) ? '0 : scan_x + coord_t'(1);
		y_next = scan_y;
		if (scan_x == H_LAST)
			y_next = (scan_y == V_LAST) ? '0 : scan_y + coord_t'(1);
	end

	// flags come from the next position so they line up with the counters.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scan_x      <= '0;
			scan_y      <= '0;
			scan_active <= 1'b1; // (0,0) is visible.
			scan_hsync  <= 1'b1;
			scan_vsync  <= 1'b1;
		end
		else
		begin
			scan_x      <= x_next;
			scan_y      <= y_next;
			scan_active <= (x_next < H_VIS) && (y_next < V_VIS);
			scan_hsync  <= !((x_next >= HS_BEGIN) && (x_next < HS_END));
			scan_vsync  <= !((y_next >= VS_BEGIN) && (y_next < VS_END)); // whole lines.
		end
	end

endmodule

`default_nettype wire

//--- test/tb_vga_overlay.sv
// ########################################
// vga overlay testbench.
// layer setups from a table, read back
// over wishbone, probed on a screen model.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module tb_vga_overlay
	import vga_overlay_pkg::*;
();

	localparam int NUM_LAYERS   = 4;
	localparam int H_ACTIVE     = 16;
	localparam int H_FRONT      = 2;
	localparam int H_SYNC       = 3;
	localparam int H_BACK       = 3;
	localparam int V_ACTIVE     = 8;
	localparam int V_FRONT      = 1;
	localparam int V_SYNC       = 2;
	localparam int V_BACK       = 1;
	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int HS_BEGIN     = H_ACTIVE + H_FRONT;
	localparam int VS_BEGIN     = V_ACTIVE + V_FRONT;
	localparam int NUM_ROWS     = 14;
	localparam int ACK_LIMIT    = 16;
	// three frames per row, a few more for reset and sync checks, 4 ns a cycle.
	localparam int WATCHDOG_NS  = (NUM_ROWS * 3 + 6) * FRAME_CYCLES * 4;

	logic     clk;
	logic     reset;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic     wb_ack;
	pixel_t   vga_rgb;
	logic     vga_hsync;
	logic     vga_vsync;

	coord_t      mx;         // screen model position of the current output.
	coord_t      my;
	logic        anchored;
	logic        prev_vs;
	int          tests;
	int          errors;
	int          row_count;
	int unsigned seed;

	string    row_name[NUM_ROWS];
	int       row_layer[NUM_ROWS];
	coord_t   row_xs[NUM_ROWS];
	coord_t   row_xe[NUM_ROWS];
	coord_t   row_ys[NUM_ROWS];
	coord_t   row_ye[NUM_ROWS];
	pixel_t   row_color[NUM_ROWS];
	logic     row_en[NUM_ROWS];
	coord_t   row_px[NUM_ROWS];
	coord_t   row_py[NUM_ROWS];
	pixel_t   row_exp[NUM_ROWS];

	coord_t sh_xs[NUM_LAYERS];   // expected layer state.
	coord_t sh_xe[NUM_LAYERS];
	coord_t sh_ys[NUM_LAYERS];
	coord_t sh_ye[NUM_LAYERS];
	pixel_t sh_col[NUM_LAYERS];
	logic   sh_en[NUM_LAYERS];

	vga_overlay_top #(
		.NUM_LAYERS (NUM_LAYERS),
		.H_ACTIVE   (H_ACTIVE),
		.H_FRONT    (H_FRONT),
		.H_SYNC     (H_SYNC),
		.H_BACK     (H_BACK),
		.V_ACTIVE   (V_ACTIVE),
		.V_FRONT    (V_FRONT),
		.V_SYNC     (V_SYNC),
		.V_BACK     (V_BACK)
	) vga_overlay_top_i (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.vga_rgb   (vga_rgb),
		.vga_hsync (vga_hsync),
		.vga_vsync (vga_vsync)
	);

	always
		#2 clk = !clk;

	// output trails the scan by one cycle and the first low vsync output is (0, VS_BEGIN).
	always @(posedge clk)
	begin
		if (reset)
		begin
			anchored <= 1'b0;
			prev_vs  <= 1'b1;
			mx       <= '0;
			my       <= '0;
		end
		else
		begin
			prev_vs <= vga_vsync;
			if (!anchored && prev_vs && !vga_vsync)
			begin
				anchored <= 1'b1;
				mx       <= coord_t'(1);
				my       <= coord_t'(VS_BEGIN);
			end
			else if (anchored)
			begin
				mx <= (int'(mx) == H_TOTAL - 1) ? '0 : mx + coord_t'(1);
				if (int'(mx) == H_TOTAL - 1)
					my <= (int'(my) == V_TOTAL - 1) ? '0 : my + coord_t'(1);
			end
		end
	end

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		tests++;
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
		else
			$display("ok %s %h", name, act);
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		tests++;
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
		else
			$display("ok %s %h", name, act);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		tests++;
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
		end
		else
			$display("ok %s %b", name, act);
	endtask

	function automatic wb_addr_t reg_addr(input int layer, input logic [2:0] idx);
		return wb_addr_t'(layer * 8) | wb_addr_t'(idx);
	endfunction

	// one classic cycle, entered and left on a falling edge.
	task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
			output wb_data_t rdata);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		n = 0;
		@(negedge clk);
		while (!wb_ack && n < ACK_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack)
		begin
			errors++;
			$display("no wishbone ack for address %h within %0d cycles", adr, ACK_LIMIT);
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
		wb_data_t unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
		bus_cycle(1'b0, adr, '0, dat);
	endtask

	task automatic wait_position(input coord_t x, input coord_t y);
		int n;
		n = 0;
		while (!(anchored && mx == x && my == y) && n < 3 * FRAME_CYCLES)
		begin
			@(negedge clk);
			n++;
		end
		if (!(anchored && mx == x && my == y))
		begin
			errors++;
			$display("screen position %0d,%0d was never reached", x, y);
		end
	endtask

	task automatic probe_pixel(input coord_t x, input coord_t y, output pixel_t pix);
		repeat (2) @(negedge clk); // let a fresh register write reach the output.
		wait_position(x, y);
		pix = vga_rgb;
	endtask

	// start inclusive, end exclusive, layers OR together, black outside the active area.
	function automatic pixel_t model_pixel(input coord_t x, input coord_t y);
		pixel_t p;
		p = '0;
		for (int l = 0; l < NUM_LAYERS; l++)
			if (sh_en[l] && x >= sh_xs[l] && x < sh_xe[l] && y >= sh_ys[l] && y < sh_ye[l])
				p = p | sh_col[l];
		if (int'(x) >= H_ACTIVE || int'(y) >= V_ACTIVE)
			p = '0;
		return p;
	endfunction

	task automatic add_row(input string name, input int layer, input int xs, input int xe,
			input int ys, input int ye, input logic en, input int px, input int py);
		row_name[row_count]  = name;
		row_layer[row_count] = layer;
		row_xs[row_count]    = coord_t'(xs);
		row_xe[row_count]    = coord_t'(xe);
		row_ys[row_count]    = coord_t'(ys);
		row_ye[row_count]    = coord_t'(ye);
		row_en[row_count]    = en;
		row_px[row_count]    = coord_t'(px);
		row_py[row_count]    = coord_t'(py);
		row_color[row_count] = pixel_t'($urandom);
		row_count++;
	endtask

	task automatic build_table();
		int l;
		add_row("single_inside",    0,  4, 10, 2,  6, 1'b1,  6,  3);
		add_row("single_start",     0,  4, 10, 2,  6, 1'b1,  4,  2);
		add_row("single_x_end",     0,  4, 10, 2,  6, 1'b1, 10,  3);
		add_row("single_y_end",     0,  4, 10, 2,  6, 1'b1,  5,  6);
		add_row("single_outside",   0,  4, 10, 2,  6, 1'b1,  1,  1);
		add_row("overlap_two",      1,  8, 14, 4,  8, 1'b1,  9,  5);
		add_row("only_layer1",      1,  8, 14, 4,  8, 1'b1, 12,  6);
		add_row("overlap_three",    2,  0, 16, 5,  7, 1'b1,  9,  5);
		add_row("disabled_layer2",  2,  0, 16, 5,  7, 1'b0,  9,  5);
		add_row("empty_layer3",     3,  6,  6, 0,  8, 1'b1,  6,  3);
		add_row("blank_hsync",      3,  0, 24, 0, 12, 1'b1, 19,  3);
		add_row("blank_front",      3,  0, 24, 0, 12, 1'b1, 17,  7);
		add_row("blank_vsync",      3,  0, 24, 0, 12, 1'b1,  3, 10);
		add_row("full_layer3",      3,  0, 24, 0, 12, 1'b1,  2,  1);
		for (int i = 0; i < NUM_LAYERS; i++)
			sh_en[i] = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			l         = row_layer[r];
			sh_xs[l]  = row_xs[r];
			sh_xe[l]  = row_xe[r];
			sh_ys[l]  = row_ys[r];
			sh_ye[l]  = row_ye[r];
			sh_col[l] = row_color[r];
			sh_en[l]  = row_en[r];
			row_exp[r] = model_pixel(row_px[r], row_py[r]);
		end
	endtask

	task automatic apply_row(input int r);
		wb_data_t vals[5];
		wb_data_t rd;
		pixel_t   pix;
		vals[REG_X_START] = wb_data_t'(row_xs[r]);
		vals[REG_X_END]   = wb_data_t'(row_xe[r]);
		vals[REG_Y_START] = wb_data_t'(row_ys[r]);
		vals[REG_Y_END]   = wb_data_t'(row_ye[r]);
		vals[REG_COLOR]   = wb_data_t'(row_color[r]) | (wb_data_t'(row_en[r]) << COLOR_EN_BIT);
		for (int k = 0; k < 5; k++)
			wb_write(reg_addr(row_layer[r], 3'(k)), vals[k]);
		for (int k = 0; k < 5; k++)
		begin
			wb_read(reg_addr(row_layer[r], 3'(k)), rd);
			check_data($sformatf("%s.reg%0d", row_name[r], k), vals[k], rd);
		end
		probe_pixel(row_px[r], row_py[r], pix);
		check_pixel(row_name[r], row_exp[r], pix);
	endtask

	task automatic check_unused_regs();
		wb_data_t rd;
		wb_write(reg_addr(0, 3'd7), 16'hffff);
		wb_read(reg_addr(0, 3'd7), rd);
		check_data("unused_reg7", '0, rd);
		wb_read(reg_addr(0, 3'd5), rd);
		check_data("unused_reg5", '0, rd);
		wb_write(reg_addr(NUM_LAYERS, REG_COLOR), 16'h1fff);
		wb_read(reg_addr(NUM_LAYERS, REG_COLOR), rd);
		check_data("missing_layer", '0, rd);
	endtask

	// one whole frame from the model's (0,0).
	task automatic check_sync_timing();
		int hs_start;
		int hs_width;
		int hs_bad;
		int vs_start;
		int vs_lines;
		hs_start = -1;
		hs_width = 0;
		hs_bad   = 0;
		vs_start = -1;
		vs_lines = 0;
		wait_position(coord_t'(0), coord_t'(0));
		for (int c = 0; c < FRAME_CYCLES; c++)
		begin
			if (!vga_hsync && my == '0)
			begin
				if (hs_width == 0)
					hs_start = int'(mx);
				hs_width++;
			end
			if (!vga_vsync && mx == '0)
			begin
				if (vs_lines == 0)
					vs_start = int'(my);
				vs_lines++;
			end
			if (vga_hsync != !(int'(mx) >= HS_BEGIN && int'(mx) < HS_BEGIN + H_SYNC))
				hs_bad++;
			@(negedge clk);
		end
		check_data("hsync_start", wb_data_t'(HS_BEGIN), wb_data_t'(hs_start));
		check_data("hsync_width", wb_data_t'(H_SYNC), wb_data_t'(hs_width));
		check_data("hsync_wrong_cycles", '0, wb_data_t'(hs_bad));
		check_data("vsync_start", wb_data_t'(VS_BEGIN), wb_data_t'(vs_start));
		check_data("vsync_lines", wb_data_t'(V_SYNC), wb_data_t'(vs_lines));
	endtask

	initial
	begin
		seed      = $urandom(32'hf346);
		clk       = 1'b0;
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		tests     = 0;
		errors    = 0;
		row_count = 0;
		build_table();
		repeat (4) @(negedge clk);
		check_bit("reset_hsync", 1'b1, vga_hsync);
		check_bit("reset_vsync", 1'b1, vga_vsync);
		check_bit("reset_ack", 1'b0, wb_ack);
		check_pixel("reset_rgb", '0, vga_rgb);
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_sync_timing();
		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(r);
		check_unused_regs();
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("simulation did not finish within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/vga_overlay_properties.sv
// ########################################
// vga overlay properties.
// bus handshake and sync pulse checks,
// bound into the top level.
// ########################################

`timescale 1ns/1ps
`default_nettype none

module vga_overlay_properties
	import vga_overlay_pkg::*;
#(
	parameter int H_SYNC = 96
)
(
	input logic   clk,
	input logic   reset,
	input logic   wb_cyc,
	input logic   wb_stb,
	input logic   wb_ack,
	input pixel_t vga_rgb,
	input logic   vga_hsync,
	input logic   vga_vsync
);

	int hs_low; // length of the current hsync low run.

	always_ff @(posedge clk)
	begin
		if (reset)
			hs_low <= 0;
		else
			hs_low <= vga_hsync ? 0 : hs_low + 1;
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wishbone ack held for more than one cycle");

	ack_after_request: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wishbone ack without a preceding cyc and stb");

	hsync_width: assert property (@(posedge clk) disable iff (reset)
		$rose(vga_hsync) |-> (hs_low == H_SYNC))
		else $error("hsync low pulse has the wrong length");

	black_in_sync: assert property (@(posedge clk) disable iff (reset)
		(!vga_hsync || !vga_vsync) |-> (vga_rgb == '0))
		else $error("rgb not black during a sync pulse");

endmodule

bind vga_overlay_top vga_overlay_properties #(
	.H_SYNC (H_SYNC)
) vga_overlay_properties_i (
	.clk       (clk),
	.reset     (reset),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_ack    (wb_ack),
	.vga_rgb   (vga_rgb),
	.vga_hsync (vga_hsync),
	.vga_vsync (vga_vsync)
);

`default_nettype wire
